/* source/motion_pkg.sv */
`default_nettype none

package motion_pkg;

    ////////////////////
    // geometry and widths
    ////////////////////

    localparam int num_players   = 2;
    localparam int x_width       = 9;
    localparam int y_width       = 8;
    localparam int count_width   = 16;
    localparam int sum_width     = 24;
    localparam int step_width    = 9;
    localparam int motion_width  = 13;
    localparam int window_frames = 8;

    // frame tally and divider step counter
    localparam int tally_width    = $clog2(window_frames);
    localparam int div_left_width = $clog2(sum_width + 1);

    typedef logic [3:0]                channel_t;
    typedef logic [x_width-1:0]        x_t;
    typedef logic [y_width-1:0]        y_t;
    typedef logic [count_width-1:0]    count_t;
    typedef logic [sum_width-1:0]      sum_t;
    typedef logic [step_width-1:0]     step_t;
    typedef logic [motion_width-1:0]   magnitude_t;
    typedef logic [tally_width-1:0]    tally_t;
    typedef logic [div_left_width-1:0] div_left_t;

    // colour thresholds, strict compares
    localparam channel_t   bright_level     = 4'd12;
    localparam channel_t   dark_level       = 4'd3;
    localparam magnitude_t action_threshold = magnitude_t'(32);

    ////////////////////
    // stream records
    ////////////////////

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef struct packed {
        logic valid;
        rgb_t rgb;
        x_t   x;
        y_t   y;
    } pixel_t;

    // one pixel credited to one player
    typedef struct packed {
        logic valid;
        x_t   x;
        y_t   y;
    } hit_t;

    typedef struct packed {
        logic frame_open;
        logic frame_close;
        logic window_end;
    } frame_ctl_t;

    // sign-magnitude motion, neg set means moving toward 0
    typedef struct packed {
        magnitude_t dx;
        logic       dx_neg;
        magnitude_t dy;
        logic       dy_neg;
    } motion_t;

    typedef struct packed {
        logic punch;
        logic kick;
    } action_t;

endpackage

`default_nettype wire

/* source/blob_sorter.sv */
`timescale 1ns/1ps
`default_nettype none

module blob_sorter (
    input  wire logic                                            clk_65mhz,
    input  wire logic                                            reset_8frame_delta_values,
    input  wire motion_pkg::pixel_t                              pixel,
    input  wire logic                                            frame_done,
    output motion_pkg::hit_t [motion_pkg::num_players-1:0]       hits,
    output motion_pkg::frame_ctl_t                               frame_ctl
);

    logic                                  is_red;
    logic                                  is_white;
    logic [motion_pkg::num_players-1:0]    claim;
    logic                                  done_q;
    logic                                  frame_open;
    motion_pkg::tally_t                    tally;

    ////////////////////
    // pixel classes
    ////////////////////

    always_comb begin
        // player 1 is the red LED
        is_red = pixel.valid
            && (pixel.rgb.r > motion_pkg::bright_level)
            && (pixel.rgb.g < motion_pkg::dark_level)
            && (pixel.rgb.b < motion_pkg::dark_level);
        // player 2 is the white LED, only if not already red
        is_white = pixel.valid && !is_red
            && (pixel.rgb.r > motion_pkg::bright_level)
            && (pixel.rgb.g > motion_pkg::bright_level)
            && (pixel.rgb.b > motion_pkg::bright_level);
        claim    = '0;
        claim[0] = is_red;
        claim[1] = is_white;
    end

    // rising edge of frame done starts a new frame
    assign frame_open = frame_done && !done_q;

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            hits      <= '0;
            frame_ctl <= '0;
            done_q    <= 1'b0;
            tally     <= '0;
        end else begin
            done_q                <= frame_done;
            frame_ctl.frame_open  <= frame_open;
            frame_ctl.frame_close <= done_q && !frame_done;
            // every eighth open closes the motion window
            frame_ctl.window_end  <= frame_open
                && (tally == motion_pkg::tally_t'(motion_pkg::window_frames - 1));
            if (frame_open) begin
                tally <= tally + 1'b1;
            end
            for (int p = 0; p < motion_pkg::num_players; p++) begin
                hits[p].valid <= claim[p];
                hits[p].x     <= pixel.x;
                hits[p].y     <= pixel.y;
            end
        end
    end

endmodule

`default_nettype wire

/* source/player_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module player_tracker (
    input  wire logic                     clk_65mhz,
    input  wire logic                     reset_8frame_delta_values,
    input  wire motion_pkg::hit_t         hit,
    input  wire motion_pkg::frame_ctl_t   frame_ctl,
    output logic                          report,
    output motion_pkg::motion_t           motion
);

    motion_pkg::count_t     count;
    motion_pkg::count_t     count_in;
    motion_pkg::sum_t       x_sum;
    motion_pkg::sum_t       x_sum_in;
    motion_pkg::sum_t       y_sum;
    motion_pkg::sum_t       y_sum_in;
    motion_pkg::count_t     div_count;
    motion_pkg::div_left_t  div_left;
    motion_pkg::sum_t       x_quo;
    motion_pkg::sum_t       x_quo_next;
    motion_pkg::count_t     x_rem;
    motion_pkg::count_t     x_rem_next;
    motion_pkg::sum_t       y_quo;
    motion_pkg::sum_t       y_quo_next;
    motion_pkg::count_t     y_rem;
    motion_pkg::count_t     y_rem_next;
    motion_pkg::x_t         cur_x;
    motion_pkg::x_t         prev_x;
    motion_pkg::y_t         cur_y;
    motion_pkg::y_t         prev_y;
    logic                   centroid_held;
    motion_pkg::step_t      step_dx;
    motion_pkg::step_t      step_dy;
    logic                   step_dx_neg;
    logic                   step_dy_neg;
    motion_pkg::motion_t    acc;
    motion_pkg::motion_t    acc_next;
    logic                   window_pending;

    // one restoring step, returns {remainder, quotient}
    function automatic logic [motion_pkg::count_width+motion_pkg::sum_width-1:0] div_step(
        input motion_pkg::count_t rem,
        input motion_pkg::sum_t   quo,
        input motion_pkg::count_t divisor
    );
        logic [motion_pkg::count_width:0] shifted;
        logic [motion_pkg::count_width:0] trial;
        shifted = {rem, quo[motion_pkg::sum_width-1]};
        trial   = shifted - {1'b0, divisor};
        if (shifted >= {1'b0, divisor}) begin
            div_step = {trial[motion_pkg::count_width-1:0],
                        quo[motion_pkg::sum_width-2:0], 1'b1};
        end else begin
            div_step = {shifted[motion_pkg::count_width-1:0],
                        quo[motion_pkg::sum_width-2:0], 1'b0};
        end
    endfunction

    // sign-magnitude add, larger magnitude keeps its sign
    function automatic logic [motion_pkg::motion_width:0] fold_axis(
        input motion_pkg::magnitude_t acc_mag,
        input logic                   acc_neg,
        input motion_pkg::step_t      step,
        input logic                   step_neg
    );
        motion_pkg::magnitude_t step_ext;
        step_ext = motion_pkg::magnitude_t'(step);
        if (acc_neg == step_neg) begin
            fold_axis = {acc_neg, acc_mag + step_ext};
        end else if (acc_mag > step_ext) begin
            fold_axis = {acc_neg, acc_mag - step_ext};
        end else begin
            fold_axis = {step_neg, step_ext - acc_mag};
        end
    endfunction

    ////////////////////
    // per-frame sums
    ////////////////////

    always_comb begin
        count_in = count + motion_pkg::count_t'(hit.valid);
        x_sum_in = hit.valid ? x_sum + motion_pkg::sum_t'(hit.x) : x_sum;
        y_sum_in = hit.valid ? y_sum + motion_pkg::sum_t'(hit.y) : y_sum;
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values || frame_ctl.frame_close) begin
            count <= '0;
            x_sum <= '0;
            y_sum <= '0;
        end else begin
            count <= count_in;
            x_sum <= x_sum_in;
            y_sum <= y_sum_in;
        end
    end

    ////////////////////
    // centroid divider
    ////////////////////

    always_comb begin
        {x_rem_next, x_quo_next} = div_step(x_rem, x_quo, div_count);
        {y_rem_next, y_quo_next} = div_step(y_rem, y_quo, div_count);
    end

    // operands latch on close, one quotient bit per cycle after that
    always_ff @(posedge clk_65mhz) begin
        if (frame_ctl.frame_close) begin
            div_count <= count_in;
            x_quo     <= x_sum_in;
            y_quo     <= y_sum_in;
            x_rem     <= '0;
            y_rem     <= '0;
        end else if (div_left != '0) begin
            x_quo <= x_quo_next;
            y_quo <= y_quo_next;
            x_rem <= x_rem_next;
            y_rem <= y_rem_next;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            div_left      <= '0;
            cur_x         <= '0;
            cur_y         <= '0;
            prev_x        <= '0;
            prev_y        <= '0;
            centroid_held <= 1'b0;
        end else if (frame_ctl.frame_close) begin
            div_left <= motion_pkg::div_left_t'(motion_pkg::sum_width);
        end else if (div_left != '0) begin
            div_left <= div_left - 1'b1;
            // last step lands the quotient
            if (div_left == motion_pkg::div_left_t'(1)) begin
                // empty frame keeps both centroids
                centroid_held <= (div_count == '0);
                if (div_count != '0) begin
                    prev_x <= cur_x;
                    prev_y <= cur_y;
                    cur_x  <= motion_pkg::x_t'(x_quo_next);
                    cur_y  <= motion_pkg::y_t'(y_quo_next);
                end
            end
        end
    end

    ////////////////////
    // 2-frame delta and window
    ////////////////////

    always_comb begin
        step_dx_neg = !centroid_held && (prev_x > cur_x);
        step_dy_neg = !centroid_held && (prev_y > cur_y);
        if (centroid_held) begin
            step_dx = '0;
            step_dy = '0;
        end else begin
            step_dx = step_dx_neg ? motion_pkg::step_t'(prev_x - cur_x)
                                  : motion_pkg::step_t'(cur_x - prev_x);
            step_dy = step_dy_neg ? motion_pkg::step_t'(prev_y - cur_y)
                                  : motion_pkg::step_t'(cur_y - prev_y);
        end
        {acc_next.dx_neg, acc_next.dx} = fold_axis(acc.dx, acc.dx_neg, step_dx, step_dx_neg);
        {acc_next.dy_neg, acc_next.dy} = fold_axis(acc.dy, acc.dy_neg, step_dy, step_dy_neg);
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            acc            <= '0;
            window_pending <= 1'b0;
            report         <= 1'b0;
            motion         <= '0;
        end else begin
            report <= window_pending;
            if (window_pending) begin
                // hand out the window and start over
                motion         <= acc;
                acc            <= '0;
                window_pending <= 1'b0;
            end else if (frame_ctl.frame_open) begin
                acc            <= acc_next;
                window_pending <= frame_ctl.window_end;
            end
        end
    end

endmodule

`default_nettype wire

/* source/action_judge.sv */
`timescale 1ns/1ps
`default_nettype none

module action_judge (
    input  wire logic                                             clk_65mhz,
    input  wire logic                                             reset_8frame_delta_values,
    input  wire logic                                             report,
    input  wire motion_pkg::motion_t [motion_pkg::num_players-1:0] motion_in,
    output logic                                                  report_valid,
    output motion_pkg::motion_t [motion_pkg::num_players-1:0]     motion,
    output motion_pkg::action_t [motion_pkg::num_players-1:0]     actions
);

    // actions from the incoming report, equality gives neither
    motion_pkg::action_t [motion_pkg::num_players-1:0] actions_next;

    always_comb begin
        for (int p = 0; p < motion_pkg::num_players; p++) begin
            actions_next[p].punch = (motion_in[p].dx > motion_pkg::action_threshold)
                                 && (motion_in[p].dy < motion_pkg::action_threshold);
            actions_next[p].kick  = (motion_in[p].dy > motion_pkg::action_threshold)
                                 && (motion_in[p].dx < motion_pkg::action_threshold);
        end
    end

    // results hold until the next window report
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            report_valid <= 1'b0;
            motion       <= '0;
            actions      <= '0;
        end else begin
            report_valid <= report;
            if (report) begin
                motion  <= motion_in;
                actions <= actions_next;
            end
        end
    end

endmodule

`default_nettype wire

/* source/motion_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module motion_tracker_top (
    input  wire logic                                          clk_65mhz,
    input  wire logic                                          reset_8frame_delta_values,
    input  wire motion_pkg::pixel_t                            pixel,
    input  wire logic                                          frame_done,
    output logic                                               report_valid,
    output motion_pkg::motion_t [motion_pkg::num_players-1:0]  motion,
    output motion_pkg::action_t [motion_pkg::num_players-1:0]  actions
);

    motion_pkg::hit_t [motion_pkg::num_players-1:0]     hits;
    motion_pkg::frame_ctl_t                             frame_ctl;
    logic [motion_pkg::num_players-1:0]                 report;
    motion_pkg::motion_t [motion_pkg::num_players-1:0]  tracker_motion;

    blob_sorter u_sorter (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel                     (pixel),
        .frame_done                (frame_done),
        .hits                      (hits),
        .frame_ctl                 (frame_ctl)
    );

    // one tracker per player, all on the same frame controls
    for (genvar p = 0; p < motion_pkg::num_players; p++) begin : g_tracker
        player_tracker u_tracker (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .hit                       (hits[p]),
            .frame_ctl                 (frame_ctl),
            .report                    (report[p]),
            .motion                    (tracker_motion[p])
        );
    end

    // trackers report in lockstep, tracker 0 stands for all
    action_judge u_judge (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .report                    (report[0]),
        .motion_in                 (tracker_motion),
        .report_valid              (report_valid),
        .motion                    (motion),
        .actions                   (actions)
    );

endmodule

`default_nettype wire

/* dv/tb_motion_model.svh */
`ifndef TB_MOTION_MODEL_SVH
`define TB_MOTION_MODEL_SVH

// per-player sums of the frame in progress
int unsigned pix_count [motion_pkg::num_players];
int unsigned x_total   [motion_pkg::num_players];
int unsigned y_total   [motion_pkg::num_players];

// centroids, held marks a last frame without hits
int cur_x  [motion_pkg::num_players];
int cur_y  [motion_pkg::num_players];
int prev_x [motion_pkg::num_players];
int prev_y [motion_pkg::num_players];
bit held   [motion_pkg::num_players];

// window totals in sign-magnitude
int acc_dx     [motion_pkg::num_players];
int acc_dy     [motion_pkg::num_players];
bit acc_dx_neg [motion_pkg::num_players];
bit acc_dy_neg [motion_pkg::num_players];

motion_pkg::motion_t want_motion [motion_pkg::num_players];
motion_pkg::action_t want_action [motion_pkg::num_players];

function automatic void clear_model();
    for (int p = 0; p < motion_pkg::num_players; p++) begin
        pix_count[p]   = 0;
        x_total[p]     = 0;
        y_total[p]     = 0;
        cur_x[p]       = 0;
        cur_y[p]       = 0;
        prev_x[p]      = 0;
        prev_y[p]      = 0;
        held[p]        = 1'b0;
        acc_dx[p]      = 0;
        acc_dy[p]      = 0;
        acc_dx_neg[p]  = 1'b0;
        acc_dy_neg[p]  = 1'b0;
        want_motion[p] = '0;
        want_action[p] = '0;
    end
endfunction

// player index of a pixel, -1 for no player
function automatic int classify(input motion_pkg::pixel_t px);
    if (!px.valid) begin
        return -1;
    end
    if (px.rgb.r > motion_pkg::bright_level && px.rgb.g < motion_pkg::dark_level
            && px.rgb.b < motion_pkg::dark_level) begin
        return 0;
    end
    if (px.rgb.r > motion_pkg::bright_level && px.rgb.g > motion_pkg::bright_level
            && px.rgb.b > motion_pkg::bright_level) begin
        return 1;
    end
    return -1;
endfunction

function automatic void add_pixel(input motion_pkg::pixel_t px);
    int p;
    p = classify(px);
    if (p >= 0) begin
        pix_count[p] = pix_count[p] + 1;
        x_total[p]   = x_total[p] + int'(px.x);
        y_total[p]   = y_total[p] + int'(px.y);
    end
endfunction

// centroid by truncating division, empty frame keeps both centroids
function automatic void close_frame();
    for (int p = 0; p < motion_pkg::num_players; p++) begin
        held[p] = (pix_count[p] == 0);
        if (!held[p]) begin
            prev_x[p] = cur_x[p];
            prev_y[p] = cur_y[p];
            cur_x[p]  = int'(x_total[p] / pix_count[p]);
            cur_y[p]  = int'(y_total[p] / pix_count[p]);
        end
        pix_count[p] = 0;
        x_total[p]   = 0;
        y_total[p]   = 0;
    end
endfunction

// opposite signs subtract, the larger magnitude keeps its sign
function automatic void fold_step(inout int mag, inout bit neg, input int step,
                                  input bit step_neg);
    if (neg == step_neg) begin
        mag = mag + step;
    end else if (mag > step) begin
        mag = mag - step;
    end else begin
        mag = step - mag;
        neg = step_neg;
    end
endfunction

function automatic void open_frame(input bit window_end);
    int step;
    bit step_neg;
    int thr;
    thr = int'(motion_pkg::action_threshold);
    for (int p = 0; p < motion_pkg::num_players; p++) begin
        step_neg = !held[p] && (prev_x[p] > cur_x[p]);
        step     = held[p] ? 0 : (step_neg ? prev_x[p] - cur_x[p] : cur_x[p] - prev_x[p]);
        fold_step(acc_dx[p], acc_dx_neg[p], step, step_neg);
        step_neg = !held[p] && (prev_y[p] > cur_y[p]);
        step     = held[p] ? 0 : (step_neg ? prev_y[p] - cur_y[p] : cur_y[p] - prev_y[p]);
        fold_step(acc_dy[p], acc_dy_neg[p], step, step_neg);
        if (window_end) begin
            want_motion[p].dx       = motion_pkg::magnitude_t'(acc_dx[p]);
            want_motion[p].dx_neg   = acc_dx_neg[p];
            want_motion[p].dy       = motion_pkg::magnitude_t'(acc_dy[p]);
            want_motion[p].dy_neg   = acc_dy_neg[p];
            want_action[p].punch    = (acc_dx[p] > thr) && (acc_dy[p] < thr);
            want_action[p].kick     = (acc_dy[p] > thr) && (acc_dx[p] < thr);
            acc_dx[p]     = 0;
            acc_dy[p]     = 0;
            acc_dx_neg[p] = 1'b0;
            acc_dy_neg[p] = 1'b0;
        end
    end
endfunction

`endif

/* dv/tb_motion_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_motion_tracker;

    localparam int num_windows    = 13;
    localparam int report_timeout = 16;

    logic                                              clk_65mhz;
    logic                                              reset_8frame_delta_values;
    motion_pkg::pixel_t                                pixel;
    logic                                              frame_done;
    logic                                              report_valid;
    motion_pkg::motion_t [motion_pkg::num_players-1:0] motion;
    motion_pkg::action_t [motion_pkg::num_players-1:0] actions;
    int                                                centre_x [motion_pkg::num_players];
    int                                                centre_y [motion_pkg::num_players];

    `include "tb_motion_model.svh"

    motion_tracker_top dut0 (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel                     (pixel),
        .frame_done                (frame_done),
        .report_valid              (report_valid),
        .motion                    (motion),
        .actions                   (actions)
    );

    initial begin
        clk_65mhz = 1'b0;
        forever #50 clk_65mhz = ~clk_65mhz;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_motion(input string name, input motion_pkg::motion_t got,
                                input motion_pkg::motion_t want);
        if (got !== want) begin
            $display("error %s got %h expected %h", name, got, want);
            fail_run();
        end
    endtask

    task automatic check_action(input string name, input motion_pkg::action_t got,
                                input motion_pkg::action_t want);
        if (got !== want) begin
            $display("error %s got %h expected %h", name, got, want);
            fail_run();
        end
    endtask

    task automatic check_outputs();
        for (int p = 0; p < motion_pkg::num_players; p++) begin
            check_motion($sformatf("motion[%0d]", p), motion[p], want_motion[p]);
            check_action($sformatf("actions[%0d]", p), actions[p], want_action[p]);
        end
    endtask

    // between windows the last results hold
    task automatic check_idle();
        if (report_valid !== 1'b0) begin
            $display("report_valid was high outside a window end");
            fail_run();
        end
        check_outputs();
    endtask

    task automatic wait_report();
        int waited;
        waited = 0;
        while (report_valid !== 1'b1) begin
            if (waited == report_timeout) begin
                $display("report_valid did not rise within %0d cycles of a window end",
                         report_timeout);
                fail_run();
            end
            @(negedge clk_65mhz);
            waited = waited + 1;
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    function automatic int limit(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // mostly small steps with now and then a jump past the threshold
    function automatic void drift_centres();
        int big;
        for (int p = 0; p < motion_pkg::num_players; p++) begin
            big = ($urandom_range(0, 4) == 0) ? 40 : 6;
            centre_x[p] = limit(centre_x[p] + int'($urandom_range(0, 2 * big)) - big, 40, 470);
            big = ($urandom_range(0, 4) == 0) ? 40 : 6;
            centre_y[p] = limit(centre_y[p] + int'($urandom_range(0, 2 * big)) - big, 30, 225);
        end
    endfunction

    function automatic motion_pkg::pixel_t random_pixel(input bit skip_red, input bit skip_white);
        int                 kind;
        int                 owner;
        motion_pkg::pixel_t px;
        kind     = int'($urandom_range(0, 9));
        owner    = -1;
        px       = '0;
        px.valid = 1'b1;
        px.x     = motion_pkg::x_t'($urandom_range(0, 511));
        px.y     = motion_pkg::y_t'($urandom_range(0, 255));
        if (kind <= 2 && !skip_red) begin
            owner    = 0;
            px.rgb.r = motion_pkg::channel_t'($urandom_range(13, 15));
            px.rgb.g = motion_pkg::channel_t'($urandom_range(0, 2));
            px.rgb.b = motion_pkg::channel_t'($urandom_range(0, 2));
        end else if (kind >= 3 && kind <= 5 && !skip_white) begin
            owner    = 1;
            px.rgb.r = motion_pkg::channel_t'($urandom_range(13, 15));
            px.rgb.g = motion_pkg::channel_t'($urandom_range(13, 15));
            px.rgb.b = motion_pkg::channel_t'($urandom_range(13, 15));
        end else if (kind <= 7 || skip_red || skip_white) begin
            // right at a threshold so nobody claims it
            case ($urandom_range(0, 3))
                0:       px.rgb = '{r: 4'd12, g: 4'd0, b: 4'd0};
                1:       px.rgb = '{r: 4'd15, g: 4'd3, b: 4'd0};
                2:       px.rgb = '{r: 4'd15, g: 4'd0, b: 4'd3};
                default: px.rgb = '{r: 4'd15, g: 4'd15, b: 4'd12};
            endcase
        end else begin
            px.valid = ($urandom_range(0, 3) != 0);
            px.rgb   = motion_pkg::rgb_t'($urandom_range(0, 4095));
        end
        if (owner >= 0) begin
            px.x = motion_pkg::x_t'(centre_x[owner] + int'($urandom_range(0, 16)) - 8);
            px.y = motion_pkg::y_t'(centre_y[owner] + int'($urandom_range(0, 16)) - 8);
        end
        return px;
    endfunction

    task automatic run_frame(input bit window_end);
        int                 n_pixels;
        int                 n_idle;
        bit                 skip_red;
        bit                 skip_white;
        motion_pkg::pixel_t px;
        n_pixels   = int'($urandom_range(30, 80));
        n_idle     = int'($urandom_range(40, 60));
        skip_red   = ($urandom_range(0, 5) == 0);
        skip_white = ($urandom_range(0, 5) == 0);
        drift_centres();
        @(negedge clk_65mhz);
        frame_done = 1'b1;
        open_frame(window_end);
        if (window_end) begin
            wait_report();
            check_outputs();
        end
        for (int i = 0; i < n_pixels; i++) begin
            @(negedge clk_65mhz);
            px    = random_pixel(skip_red, skip_white);
            pixel = px;
            add_pixel(px);
        end
        @(negedge clk_65mhz);
        pixel      = '0;
        frame_done = 1'b0;
        close_frame();
        repeat (n_idle) begin
            @(negedge clk_65mhz);
            check_idle();
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        reset_8frame_delta_values = 1'b1;
        pixel                     = '0;
        frame_done                = 1'b0;
        void'($urandom(32'h80b77ad9));
        clear_model();
        for (int p = 0; p < motion_pkg::num_players; p++) begin
            centre_x[p] = 120 + 240 * p;
            centre_y[p] = 128;
        end
        repeat (8) @(posedge clk_65mhz);
        @(negedge clk_65mhz);
        reset_8frame_delta_values = 1'b0;
        check_idle();
        for (int f = 1; f <= num_windows * motion_pkg::window_frames; f++) begin
            run_frame((f % motion_pkg::window_frames) == 0);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+dv
source/motion_pkg.sv
source/blob_sorter.sv
source/player_tracker.sv
source/action_judge.sv
source/motion_tracker_top.sv
dv/tb_motion_tracker.sv

/* run.sh */
#!/bin/sh
# build and run the motion tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
    --top-module tb_motion_tracker --Mdir obj_dir -o sim_motion_tracker
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_motion_tracker > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failures"
exit 0
